// File: rtl/lcd_msg_pkg.sv
package lcd_msg_pkg;

    // ================================================
    // Display geometry and character types
    // ================================================

    // 16x2 character module
    localparam int lcd_cols = 16;

    // One ASCII character
    typedef logic [7:0] char_t;

    // Whole display line, leftmost character in the top byte
    typedef logic [8*lcd_cols-1:0] line_t;

    // Short name field, NUL padded on the left
    typedef logic [8*8-1:0] label_t;

    // Brew progress in percent, may exceed 100
    typedef logic [7:0] percent_t;

    // Warning counter from the consumable monitor
    typedef logic [3:0] warn_count_t;

    // Coffee bin index
    typedef logic [2:0] bin_sel_t;

    // ================================================
    // Encodings shared with the menu FSM
    // ================================================

    // Codes 10 to 15 are undefined
    typedef enum logic [3:0] {
        splash        = 4'd0,
        check_errors  = 4'd1,
        coffee_select = 4'd2,
        drink_select  = 4'd3,
        size_select   = 4'd4,
        confirm       = 4'd5,
        brewing       = 4'd6,
        complete      = 4'd7,
        settings      = 4'd8,
        error         = 4'd9
    } menu_state_e;

    // Codes 5 to 7 are undefined
    typedef enum logic [2:0] {
        black     = 3'd0,
        cream     = 3'd1,
        latte     = 3'd2,
        mocha     = 3'd3,
        hot_choco = 3'd4
    } drink_e;

    // Code 3 is undefined
    typedef enum logic [1:0] {
        oz8  = 2'd0,
        oz12 = 2'd1,
        oz16 = 2'd2
    } cup_size_e;

    // ================================================
    // Glyphs
    // ================================================

    localparam char_t glyph_space = 8'h20;
    localparam char_t glyph_fill  = 8'h23;
    localparam char_t glyph_empty = 8'h2d;

    localparam line_t blank_line = {lcd_cols{glyph_space}};

    // ASCII digit, space when out of range
    function automatic char_t digit_char(input warn_count_t value);
        return (value < 4'd10) ? char_t'(8'h30 + value) : glyph_space;
    endfunction

    // Drink name, all zero for an undefined code
    function automatic label_t drink_label(input drink_e drink);
        case (drink)
            black:     return label_t'("Black");
            cream:     return label_t'("Cream");
            latte:     return label_t'("Latte");
            mocha:     return label_t'("Mocha");
            hot_choco: return label_t'("HotChoco");
            default:   return '0;
        endcase
    endfunction

    // Cup size name, all zero for an undefined code
    function automatic label_t size_label(input cup_size_e cup_size);
        case (cup_size)
            oz8:     return label_t'("8oz");
            oz12:    return label_t'("12oz");
            oz16:    return label_t'("16oz");
            default: return '0;
        endcase
    endfunction

endpackage

// File: rtl/machine_status_if.sv
interface machine_status_if;

    // Coffee bin levels
    logic bin0_empty;
    logic bin0_low;
    logic bin1_empty;
    logic bin1_low;

    // Cup paper supply
    logic paper_empty;

    // Water system readiness, active high
    logic temp_ready;
    logic pressure_ready;

    // Top level fills the flags
    modport producer (
        output bin0_empty, bin0_low, bin1_empty, bin1_low,
        output paper_empty, temp_ready, pressure_ready
    );

    // Screen composer only reads them
    modport consumer (
        input bin0_empty, bin0_low, bin1_empty, bin1_low,
        input paper_empty, temp_ready, pressure_ready
    );

endinterface

// File: rtl/progress_bar_gen.sv
module progress_bar_gen (
    input  lcd_msg_pkg::percent_t brew_progress,
    output lcd_msg_pkg::line_t    bar
);
    import lcd_msg_pkg::*;

    // Progress scaled by 16, up to 4080
    logic [11:0] scaled;
    // Filled cell count, up to 40 before the line runs out
    logic [5:0]  filled;

    // ================================================
    // Cell count
    // ================================================

    always_comb begin
        // Times 16 is a plain shift
        scaled = {brew_progress, 4'b0000};
        // Truncating divide, anything past 16 saturates below
        filled = 6'(scaled / 12'd100);
    end

    // ================================================
    // Bar glyphs
    // ================================================

    always_comb begin
        for (int i = 0; i < lcd_cols; i++) begin
            // Leftmost cell in the top byte
            if (i < int'(filled)) begin
                bar[8*(lcd_cols-1-i) +: 8] = glyph_fill;
            end else begin
                bar[8*(lcd_cols-1-i) +: 8] = glyph_empty;
            end
        end
    end

endmodule

// File: rtl/screen_composer.sv
module screen_composer (
    input  lcd_msg_pkg::menu_state_e menu_state,
    input  lcd_msg_pkg::bin_sel_t    coffee_bin,
    input  lcd_msg_pkg::drink_e      drink,
    input  lcd_msg_pkg::cup_size_e   cup_size,
    input  lcd_msg_pkg::warn_count_t warnings,
    machine_status_if.consumer       status,
    input  lcd_msg_pkg::line_t       bar,
    output lcd_msg_pkg::line_t       line1_next,
    output lcd_msg_pkg::line_t       line2_next
);
    import lcd_msg_pkg::*;

    // Scratch text wider than the longest concatenated screen
    localparam int raw_chars = 24;
    typedef logic [8*raw_chars-1:0] raw_t;

    label_t drink_name;
    label_t size_name;
    logic   bin_empty;
    logic   bin_low;
    char_t  bin_digit;

    // ================================================
    // Text packing
    // ================================================

    // Drops NUL characters, left aligns, pads with spaces
    // Text past column 16 is cut off
    function automatic line_t squeeze(input raw_t raw);
        line_t text;
        char_t ch;
        int    col;
        text = blank_line;
        col  = 0;
        for (int i = raw_chars - 1; i >= 0; i--) begin
            ch = raw[8*i +: 8];
            if (ch != 8'h00) begin
                if (col < lcd_cols) begin
                    text[8*(lcd_cols-1-col) +: 8] = ch;
                end
                col++;
            end
        end
        return text;
    endfunction

    // ================================================
    // Selection lookups
    // ================================================

    // Zero label marks an undefined code
    assign drink_name = drink_label(drink);
    assign size_name  = size_label(cup_size);

    // Bin 0 is shown as [1] and any other index as bin 1
    assign bin_digit = (coffee_bin == '0) ? char_t'("1") : char_t'("2");
    assign bin_empty = (coffee_bin == '0) ? status.bin0_empty : status.bin1_empty;
    assign bin_low   = (coffee_bin == '0) ? status.bin0_low : status.bin1_low;

    // ================================================
    // Screen selection
    // ================================================

    always_comb begin
        line1_next = blank_line;
        line2_next = blank_line;

        case (menu_state)
            splash: begin
                line1_next = squeeze("Press Start");
                // Count above 9 leaves a space in the digit slot
                if (warnings != '0) begin
                    line2_next = squeeze({"Warnings: ", digit_char(warnings)});
                end else begin
                    line2_next = squeeze("Ready");
                end
            end

            check_errors: begin
                line1_next = squeeze("Checking...");
                line2_next = squeeze("Please wait");
            end

            coffee_select: begin
                line1_next = squeeze({"Coffee: [", bin_digit, "]"});
                // Empty wins over low
                if (bin_empty) begin
                    line2_next = squeeze("Empty!");
                end else if (bin_low) begin
                    line2_next = squeeze("Low");
                end else begin
                    line2_next = squeeze("<-> Select");
                end
            end

            drink_select: begin
                // Long names lose the closing bracket
                if (drink_name == '0) begin
                    line1_next = squeeze("Drink: ?");
                end else begin
                    line1_next = squeeze({"Drink: [", drink_name, "]"});
                end
                line2_next = squeeze("<-> Select");
            end

            size_select: begin
                if (size_name == '0) begin
                    line1_next = squeeze("Size: ?");
                end else begin
                    line1_next = squeeze({"Size: [", size_name, "]"});
                end
                line2_next = squeeze("<-> Select");
            end

            confirm: begin
                // Stays blank unless both codes are defined
                if (drink_name != '0 && size_name != '0) begin
                    line1_next = squeeze({drink_name, " ", size_name});
                end
                line2_next = squeeze("Start? Cancel?");
            end

            brewing: begin
                line1_next = squeeze("Brewing...");
                line2_next = bar;
            end

            complete: begin
                line1_next = squeeze("Enjoy!");
                line2_next = squeeze("Press any key");
            end

            settings: begin
                line1_next = squeeze("Settings Mode");
                line2_next = squeeze("Cancel to exit");
            end

            error: begin
                // Cause priority starts with the water system
                if (!status.temp_ready) begin
                    line1_next = squeeze("WATER TEMP!");
                end else if (!status.pressure_ready) begin
                    line1_next = squeeze("WATER ERROR!");
                end else if (status.paper_empty) begin
                    line1_next = squeeze("NO PAPER!");
                end else if (status.bin0_empty && status.bin1_empty) begin
                    line1_next = squeeze("NO COFFEE!");
                end else begin
                    line1_next = squeeze("SYSTEM FAULT!");
                end
                line2_next = squeeze("Fix & restart");
            end

            // Undefined codes 10 to 15
            default: begin
                line1_next = squeeze("ERROR");
                line2_next = blank_line;
            end
        endcase
    end

endmodule

// File: rtl/lcd_text_latch.sv
module lcd_text_latch (
    input  logic               clk,
    input  logic               rst_n,
    input  lcd_msg_pkg::line_t line1_next,
    input  lcd_msg_pkg::line_t line2_next,
    output lcd_msg_pkg::line_t line1_text,
    output lcd_msg_pkg::line_t line2_text,
    output logic               message_updated
);
    import lcd_msg_pkg::*;

    // ================================================
    // Displayed text and change pulse
    // ================================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            // Blank panel while in reset
            line1_text      <= blank_line;
            line2_text      <= blank_line;
            message_updated <= 1'b0;
        end else begin
            line1_text <= line1_next;
            line2_text <= line2_next;
            // High for one cycle when either line takes new text
            message_updated <= (line1_next != line1_text) ||
                               (line2_next != line2_text);
        end
    end

endmodule

// File: rtl/lcd_msg_top.sv
module lcd_msg_top (
    input  logic               clk,
    input  logic               rst_n,
    // Menu FSM outputs
    input  logic [3:0]         current_menu_state,
    input  logic [2:0]         selected_coffee_type,
    input  logic [2:0]         selected_drink_type,
    input  logic [1:0]         selected_size,
    // Machine status
    input  logic [7:0]         brew_progress,
    input  logic [3:0]         warning_count,
    input  logic               bin0_empty,
    input  logic               bin0_low,
    input  logic               bin1_empty,
    input  logic               bin1_low,
    input  logic               paper_empty,
    input  logic               temp_ready,
    input  logic               pressure_ready,
    // Display text
    output lcd_msg_pkg::line_t line1_text,
    output lcd_msg_pkg::line_t line2_text,
    output logic               message_updated
);
    import lcd_msg_pkg::*;

    machine_status_if status_bus ();

    line_t bar_line;
    line_t line1_next;
    line_t line2_next;

    // ================================================
    // Status flags onto the bus
    // ================================================

    assign status_bus.bin0_empty     = bin0_empty;
    assign status_bus.bin0_low       = bin0_low;
    assign status_bus.bin1_empty     = bin1_empty;
    assign status_bus.bin1_low       = bin1_low;
    assign status_bus.paper_empty    = paper_empty;
    assign status_bus.temp_ready     = temp_ready;
    assign status_bus.pressure_ready = pressure_ready;

    // ================================================
    // Bar, composer, output register
    // ================================================

    progress_bar_gen u_bar (
        .brew_progress (brew_progress),
        .bar           (bar_line)
    );

    // Raw codes pass through unchecked, undefined ones hit the defaults
    screen_composer u_composer (
        .menu_state (menu_state_e'(current_menu_state)),
        .coffee_bin (selected_coffee_type),
        .drink      (drink_e'(selected_drink_type)),
        .cup_size   (cup_size_e'(selected_size)),
        .warnings   (warning_count),
        .status     (status_bus.consumer),
        .bar        (bar_line),
        .line1_next (line1_next),
        .line2_next (line2_next)
    );

    lcd_text_latch u_latch (
        .clk             (clk),
        .rst_n           (rst_n),
        .line1_next      (line1_next),
        .line2_next      (line2_next),
        .line1_text      (line1_text),
        .line2_text      (line2_text),
        .message_updated (message_updated)
    );

endmodule

// File: verification/lcd_msg_props.sv
module lcd_msg_props (
    input logic               clk,
    input logic               rst_n,
    input lcd_msg_pkg::line_t line1_text,
    input lcd_msg_pkg::line_t line2_text,
    input logic               message_updated
);
    timeunit 1ns;
    timeprecision 1ps;
    import lcd_msg_pkg::*;

    // Failed assertions, read by the testbench summary
    int unsigned fail_count = 0;

    // ================================================
    // Output properties
    // ================================================

    // Blank panel and no pulse while reset is held
    reset_blank: assert property (@(posedge clk)
        !rst_n |-> (line1_text == blank_line && line2_text == blank_line && !message_updated))
        else begin
            $error("display not blank during reset");
            fail_count++;
        end

    // Pulse only after one of the lines changed
    no_idle_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        message_updated |-> (line1_text != $past(line1_text) || line2_text != $past(line2_text)))
        else begin
            $error("message_updated high with unchanged text");
            fail_count++;
        end

    // Every change is flagged
    change_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        (line1_text != $past(line1_text) || line2_text != $past(line2_text)) |-> message_updated)
        else begin
            $error("text changed without message_updated");
            fail_count++;
        end

endmodule

bind lcd_msg_top lcd_msg_props u_props (.*);

// File: verification/lcd_msg_tb.sv
module lcd_msg_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import lcd_msg_pkg::*;

    localparam logic [31:0] lfsr_seed = 32'hcaf06b13;
    localparam int clk_period   = 40;
    localparam int reset_cycles = 10;
    localparam int n_random     = 48;
    // Reset, splash, selection, three random tests plus fixed states, pulse test
    localparam int total_cycles = reset_cycles + 16 + 44 + 3*n_random + 9 + 19;
    localparam int watchdog_ns  = (total_cycles + 20) * clk_period;

    logic clk;
    logic rst_n;
    logic [3:0] menu_state;
    logic [2:0] coffee_type;
    logic [2:0] drink_type;
    logic [1:0] size_code;
    logic [7:0] progress;
    logic [3:0] warn_count;
    logic bin0_empty, bin0_low, bin1_empty, bin1_low;
    logic paper_empty, temp_ready, pressure_ready;
    line_t line1_text;
    line_t line2_text;
    logic message_updated;

    logic [31:0] lfsr;
    // Text the display held before the last edge
    line_t prev1;
    line_t prev2;
    int test_checks, test_errors, total_checks, total_errors;

    lcd_msg_top UUT (
        .clk                  (clk),
        .rst_n                (rst_n),
        .current_menu_state   (menu_state),
        .selected_coffee_type (coffee_type),
        .selected_drink_type  (drink_type),
        .selected_size        (size_code),
        .brew_progress        (progress),
        .warning_count        (warn_count),
        .bin0_empty           (bin0_empty),
        .bin0_low             (bin0_low),
        .bin1_empty           (bin1_empty),
        .bin1_low             (bin1_low),
        .paper_empty          (paper_empty),
        .temp_ready           (temp_ready),
        .pressure_ready       (pressure_ready),
        .line1_text           (line1_text),
        .line2_text           (line2_text),
        .message_updated      (message_updated)
    );

    // ================================================
    // Random source and reference model
    // ================================================

    // Galois LFSR stepped once per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
        end
        return v;
    endfunction

    // Left aligned, space padded, cut at column 16
    function automatic line_t to_line(input string s);
        line_t l;
        l = blank_line;
        for (int i = 0; i < s.len() && i < lcd_cols; i++) begin
            l[8*(lcd_cols-1-i) +: 8] = s[i];
        end
        return l;
    endfunction

    function automatic string drink_name_of(input logic [2:0] code);
        case (code)
            3'd0: return "Black";
            3'd1: return "Cream";
            3'd2: return "Latte";
            3'd3: return "Mocha";
            3'd4: return "HotChoco";
            default: return "";
        endcase
    endfunction

    function automatic string size_name_of(input logic [1:0] code);
        case (code)
            2'd0: return "8oz";
            2'd1: return "12oz";
            2'd2: return "16oz";
            default: return "";
        endcase
    endfunction

    // Cells are progress * 16 / 100 truncated and capped at 16
    function automatic line_t bar_model(input logic [7:0] pct);
        line_t l;
        int cells;
        cells = (int'(pct) * 16) / 100;
        if (cells > lcd_cols) cells = lcd_cols;
        for (int i = 0; i < lcd_cols; i++) begin
            l[8*(lcd_cols-1-i) +: 8] = (i < cells) ? glyph_fill : glyph_empty;
        end
        return l;
    endfunction

    task automatic model_screen(output line_t l1, output line_t l2);
        string s1, s2, dn, sn;
        logic sel_empty, sel_low;
        s1 = "";
        s2 = "";
        dn = drink_name_of(drink_type);
        sn = size_name_of(size_code);
        // Bin 0 is [1] and every other index is bin 1
        sel_empty = (coffee_type == 3'd0) ? bin0_empty : bin1_empty;
        sel_low = (coffee_type == 3'd0) ? bin0_low : bin1_low;
        case (menu_state)
            4'd0: begin
                s1 = "Press Start";
                if (warn_count == 4'd0) s2 = "Ready";
                else if (warn_count < 4'd10) s2 = $sformatf("Warnings: %0d", warn_count);
                else s2 = "Warnings: ";
            end
            4'd1: begin
                s1 = "Checking...";
                s2 = "Please wait";
            end
            4'd2: begin
                if (coffee_type == 3'd0) s1 = "Coffee: [1]";
                else s1 = "Coffee: [2]";
                if (sel_empty) s2 = "Empty!";
                else if (sel_low) s2 = "Low";
                else s2 = "<-> Select";
            end
            4'd3: begin
                if (dn == "") s1 = "Drink: ?";
                else s1 = {"Drink: [", dn, "]"};
                s2 = "<-> Select";
            end
            4'd4: begin
                if (sn == "") s1 = "Size: ?";
                else s1 = {"Size: [", sn, "]"};
                s2 = "<-> Select";
            end
            4'd5: begin
                if (dn != "" && sn != "") s1 = {dn, " ", sn};
                s2 = "Start? Cancel?";
            end
            4'd6: s1 = "Brewing...";
            4'd7: begin
                s1 = "Enjoy!";
                s2 = "Press any key";
            end
            4'd8: begin
                s1 = "Settings Mode";
                s2 = "Cancel to exit";
            end
            4'd9: begin
                // Water temp, pressure, paper, both bins, then fault
                if (!temp_ready) s1 = "WATER TEMP!";
                else if (!pressure_ready) s1 = "WATER ERROR!";
                else if (paper_empty) s1 = "NO PAPER!";
                else if (bin0_empty && bin1_empty) s1 = "NO COFFEE!";
                else s1 = "SYSTEM FAULT!";
                s2 = "Fix & restart";
            end
            default: s1 = "ERROR";
        endcase
        l1 = to_line(s1);
        l2 = (menu_state == 4'd6) ? bar_model(progress) : to_line(s2);
    endtask

    // ================================================
    // Checks and bookkeeping
    // ================================================

    task automatic report_mismatch(input string name, input string what,
                                   input string expected, input string actual);
        $display("FAILED %s: %s expected \"%s\" actual \"%s\"", name, what, expected, actual);
        test_errors++;
    endtask

    task automatic check_step(input string name);
        line_t exp1, exp2;
        logic exp_pulse;
        model_screen(exp1, exp2);
        exp_pulse = (exp1 != prev1) || (exp2 != prev2);
        test_checks++;
        assert (line1_text == exp1)
            else report_mismatch(name, "line 1", $sformatf("%s", exp1),
                                 $sformatf("%s", line1_text));
        assert (line2_text == exp2)
            else report_mismatch(name, "line 2", $sformatf("%s", exp2),
                                 $sformatf("%s", line2_text));
        assert (message_updated == exp_pulse)
            else report_mismatch(name, "pulse", $sformatf("%b", exp_pulse),
                                 $sformatf("%b", message_updated));
        prev1 = exp1;
        prev2 = exp2;
    endtask

    task automatic check_blank(input string name);
        test_checks++;
        assert (line1_text == blank_line && line2_text == blank_line)
            else report_mismatch(name, "reset text",
                                 $sformatf("%s|%s", blank_line, blank_line),
                                 $sformatf("%s|%s", line1_text, line2_text));
        assert (!message_updated)
            else report_mismatch(name, "reset pulse", "0", $sformatf("%b", message_updated));
    endtask

    // Result of the inputs that were set before the rising edge
    task automatic step(input string name);
        @(negedge clk);
        check_step(name);
    endtask

    task automatic random_fields();
        coffee_type = 3'(rand_bits(3));
        drink_type = 3'(rand_bits(3));
        size_code = 2'(rand_bits(2));
        progress = 8'(rand_bits(8));
        warn_count = 4'(rand_bits(4));
        bin0_empty = rand_bits(1) != 0;
        bin0_low = rand_bits(1) != 0;
        bin1_empty = rand_bits(1) != 0;
        bin1_low = rand_bits(1) != 0;
        paper_empty = rand_bits(1) != 0;
        // Ready three times out of four so deeper causes show up
        temp_ready = rand_bits(2) != 0;
        pressure_ready = rand_bits(2) != 0;
    endtask

    task automatic end_test(input string name);
        $display("test %-10s %0d checks, %0d errors", name, test_checks, test_errors);
        total_checks += test_checks;
        total_errors += test_errors;
        test_checks = 0;
        test_errors = 0;
    endtask

    // ================================================
    // Clock, watchdog, test sequence
    // ================================================

    initial begin
        clk = 1'b0;
        forever #(clk_period/2) clk = ~clk;
    end

    initial begin
        #(watchdog_ns);
        $display("Watchdog expired after %0d ns, tests did not finish", watchdog_ns);
        $display("Something failed");
        $finish;
    end

    initial begin
        lfsr = lfsr_seed;
        {test_checks, test_errors, total_checks, total_errors} = '0;
        menu_state = 4'd0;
        random_fields();
        prev1 = blank_line;
        prev2 = blank_line;
        rst_n = 1'b1;
        #1 rst_n = 1'b0;
        repeat (reset_cycles) @(negedge clk);
        check_blank("reset");
        rst_n = 1'b1;
        end_test("reset");

        // Warning digit for every count
        for (int w = 0; w < 16; w++) begin
            random_fields();
            warn_count = 4'(w);
            step("splash");
        end
        end_test("splash");

        menu_state = 4'd2;
        repeat (n_random) begin
            random_fields();
            step("coffee");
        end
        end_test("coffee");

        // Every drink and size code including the undefined ones
        menu_state = 4'd3;
        for (int d = 0; d < 8; d++) begin
            drink_type = 3'(d);
            step("selection");
        end
        menu_state = 4'd4;
        for (int s = 0; s < 4; s++) begin
            size_code = 2'(s);
            step("selection");
        end
        menu_state = 4'd5;
        for (int c = 0; c < 32; c++) begin
            drink_type = 3'(c >> 2);
            size_code = 2'(c);
            step("selection");
        end
        end_test("selection");

        menu_state = 4'd6;
        repeat (n_random) begin
            random_fields();
            step("brew_bar");
        end
        end_test("brew_bar");

        menu_state = 4'd9;
        repeat (n_random) begin
            random_fields();
            step("error");
        end
        // Fixed screens and then undefined codes 10 to 15
        for (int m = 0; m < 9; m++) begin
            menu_state = (m < 3) ? ((m == 0) ? 4'd1 : 4'(m + 6)) : 4'(m + 7);
            step("error");
        end
        end_test("error");

        // Same inputs for four cycles with a pulse only on the first
        for (int k = 0; k < 4; k++) begin
            menu_state = 4'(rand_bits(4));
            random_fields();
            repeat (4) step("pulse");
        end
        // Reset in the middle of a run blanks the panel
        rst_n = 1'b0;
        @(negedge clk);
        check_blank("pulse");
        rst_n = 1'b1;
        prev1 = blank_line;
        prev2 = blank_line;
        repeat (2) step("pulse");
        end_test("pulse");

        $display("checks %0d, errors %0d, assertion failures %0d",
                 total_checks, total_errors, UUT.u_props.fail_count);
        if (total_errors == 0 && UUT.u_props.fail_count == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// File: flist.f
rtl/lcd_msg_pkg.sv
rtl/machine_status_if.sv
rtl/progress_bar_gen.sv
rtl/screen_composer.sv
rtl/lcd_text_latch.sv
rtl/lcd_msg_top.sv
verification/lcd_msg_props.sv
verification/lcd_msg_tb.sv

// File: Bender.yml
package:
  name: lcd_msg

sources:
  # Design, package first
  - files:
      - rtl/lcd_msg_pkg.sv
      - rtl/machine_status_if.sv
      - rtl/progress_bar_gen.sv
      - rtl/screen_composer.sv
      - rtl/lcd_text_latch.sv
      - rtl/lcd_msg_top.sv
  # Testbench and bound properties
  - target: test
    files:
      - verification/lcd_msg_props.sv
      - verification/lcd_msg_tb.sv
